//--- src/psx_cfg_pkg.sv
package psx_cfg_pkg;

	// ============================================================
	// Widths
	// ============================================================

	// RAM side
	localparam int RAM_ADDR_W = 27;
	localparam int RAM_DATA_W = 32;
	localparam int RAM_BE_W   = 4;

	// Host download stream
	localparam int HOST_W = 16;
	localparam int IDX_W  = 8;

	// Media
	localparam int CD_SIZE_W  = 30;
	localparam int IMG_SIZE_W = 32;
	localparam int CARD_COUNT = 2;

	// ============================================================
	// Address map
	// ============================================================

	// Byte offsets of the download targets in RAM
	localparam logic [31:0] BIOS_START = 32'd2097152;
	localparam logic [31:0] EXE_START  = 32'd4194304;

	// ============================================================
	// Download index codes
	// ============================================================

	localparam logic [IDX_W-1:0] IDX_BIOS = 8'd0;
	localparam logic [IDX_W-1:0] IDX_EXE  = 8'd1;

	// CD images arrive on several indices where only the low bits count
	localparam int IDX_CD_BITS = 6;
	localparam logic [IDX_CD_BITS-1:0] IDX_CD = 6'd2;

endpackage

//--- src/psx_bus_pkg.sv
package psx_bus_pkg;

	// ============================================================
	// Plain vector types
	// ============================================================

	typedef logic [psx_cfg_pkg::RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [psx_cfg_pkg::RAM_DATA_W-1:0] ram_word_t;
	typedef logic [psx_cfg_pkg::RAM_BE_W-1:0]   ram_be_t;
	typedef logic [psx_cfg_pkg::HOST_W-1:0]     host_word_t;
	typedef logic [psx_cfg_pkg::IDX_W-1:0]      dl_index_t;
	typedef logic [psx_cfg_pkg::CD_SIZE_W-1:0]  cd_size_t;
	typedef logic [psx_cfg_pkg::IMG_SIZE_W-1:0] img_size_t;

	// ============================================================
	// State encodings
	// ============================================================

	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD
	} dl_kind_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_DL,
		ARB_SYS
	} arb_state_e;

	// ============================================================
	// Bus bundles
	// ============================================================

	// Host download stream carrying one 16-bit word per strobe
	typedef struct packed {
		logic       active;
		dl_index_t  index;
		ram_addr_t  addr;
		host_word_t data;
		logic       wr;
	} host_dl_t;

	// Image mount pulses with one size shared by all slots
	typedef struct packed {
		logic                              cd;
		logic [psx_cfg_pkg::CARD_COUNT-1:0] card;
		img_size_t                         size;
	} mount_t;

	typedef struct packed {
		ram_addr_t addr;
		ram_word_t wdata;
		ram_be_t   be;
		logic      rnw;
	} ram_req_t;

endpackage

//--- src/download_decoder.sv
`timescale 1ns/100ps

module download_decoder (
	input  logic                  clk_1x,
	input  logic                  arst_n,
	input  psx_bus_pkg::host_dl_t host,
	output psx_bus_pkg::dl_kind_e dl_kind,
	output logic                  system_reset,
	output logic                  exe_loaded,
	output logic                  cd_loaded
);

	psx_bus_pkg::dl_kind_e kind_next;
	psx_bus_pkg::dl_kind_e kind_d1;

	// ============================================================
	// Index decode
	// ============================================================

	always_comb begin
		kind_next = psx_bus_pkg::DL_NONE;
		if (host.active) begin
			if (host.index == psx_cfg_pkg::IDX_BIOS)
				kind_next = psx_bus_pkg::DL_BIOS;
			else if (host.index == psx_cfg_pkg::IDX_EXE)
				kind_next = psx_bus_pkg::DL_EXE;
			else if (host.index[psx_cfg_pkg::IDX_CD_BITS-1:0] == psx_cfg_pkg::IDX_CD)
				kind_next = psx_bus_pkg::DL_CD;
		end
	end

	// ============================================================
	// Registered kind and end-of-download pulses
	// ============================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind      <= psx_bus_pkg::DL_NONE;
			kind_d1      <= psx_bus_pkg::DL_NONE;
			system_reset <= 1'b0;
			exe_loaded   <= 1'b0;
			cd_loaded    <= 1'b0;
		end else begin
			dl_kind <= kind_next;
			kind_d1 <= dl_kind;

			// System held in reset for every recognised download
			system_reset <= (kind_next != psx_bus_pkg::DL_NONE);

			// Falling edge of the registered kind
			exe_loaded <= (kind_d1 == psx_bus_pkg::DL_EXE) &&
				(dl_kind != psx_bus_pkg::DL_EXE);
			cd_loaded  <= (kind_d1 == psx_bus_pkg::DL_CD) &&
				(dl_kind != psx_bus_pkg::DL_CD);
		end
	end

	// Host words only arrive inside a download
	a_wr_in_download: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		host.wr |-> host.active
	);

endmodule

//--- src/download_packer.sv
`timescale 1ns/100ps

module download_packer (
	input  logic                  clk_1x,
	input  logic                  arst_n,
	input  psx_bus_pkg::host_dl_t host,
	input  psx_bus_pkg::dl_kind_e dl_kind,
	output psx_bus_pkg::ram_req_t dl_req,
	output logic                  dl_valid,
	input  logic                  dl_ack,
	output logic                  host_wait
);

	logic                   pack_en;
	logic                   odd_half;
	psx_bus_pkg::ram_addr_t base;
	psx_bus_pkg::ram_addr_t req_addr;
	psx_bus_pkg::ram_word_t req_data;

	// Only BIOS and EXE images go to RAM
	assign pack_en = (dl_kind == psx_bus_pkg::DL_BIOS) ||
		(dl_kind == psx_bus_pkg::DL_EXE);

	assign odd_half = host.addr[1];

	assign base = (dl_kind == psx_bus_pkg::DL_EXE) ?
		psx_bus_pkg::ram_addr_t'(psx_cfg_pkg::EXE_START) :
		psx_bus_pkg::ram_addr_t'(psx_cfg_pkg::BIOS_START);

	// ============================================================
	// Word assembly
	// ============================================================

	always_ff @(posedge clk_1x) begin
		if (pack_en && host.wr) begin
			if (!odd_half) begin
				req_addr       <= host.addr + base;
				req_data[15:0] <= host.data;
			end else begin
				req_data[31:16] <= host.data;
			end
		end
	end

	// Full 32-bit writes only
	assign dl_req = '{
		addr:  req_addr,
		wdata: req_data,
		be:    '1,
		rnw:   1'b0
	};

	// ============================================================
	// Request and host flow control
	// ============================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_valid  <= 1'b0;
			host_wait <= 1'b0;
		end else begin
			if (pack_en && host.wr && odd_half) begin
				dl_valid  <= 1'b1;
				host_wait <= 1'b1;
			end
			// Request stays up until memory takes it
			if (dl_ack) begin
				dl_valid  <= 1'b0;
				host_wait <= 1'b0;
			end
			if (!pack_en)
				host_wait <= 1'b0;
		end
	end

	// Host must honour the wait flag
	a_no_wr_while_wait: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		host_wait |-> !host.wr
	);

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  psx_bus_pkg::dl_kind_e  dl_kind,
	input  psx_bus_pkg::ram_req_t  dl_req,
	input  logic                   dl_valid,
	output logic                   dl_ack,
	input  psx_bus_pkg::ram_req_t  sys_req,
	input  logic                   sys_valid,
	output logic                   sys_ack,
	output psx_bus_pkg::ram_word_t sys_rdata,
	output psx_bus_pkg::ram_req_t  ram_req,
	output logic                   ram_valid,
	input  logic                   ram_ack,
	input  psx_bus_pkg::ram_word_t ram_rdata
);

	psx_bus_pkg::arb_state_e state;
	logic                    dl_owns;

	// System side waits out the whole BIOS or EXE download
	assign dl_owns = (dl_kind == psx_bus_pkg::DL_BIOS) ||
		(dl_kind == psx_bus_pkg::DL_EXE);

	// ============================================================
	// Grant FSM
	// ============================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			state     <= psx_bus_pkg::ARB_IDLE;
			ram_valid <= 1'b0;
		end else begin
			case (state)
				psx_bus_pkg::ARB_IDLE: begin
					if (dl_valid) begin
						state     <= psx_bus_pkg::ARB_DL;
						ram_valid <= 1'b1;
					end else if (sys_valid && !dl_owns) begin
						state     <= psx_bus_pkg::ARB_SYS;
						ram_valid <= 1'b1;
					end
				end
				psx_bus_pkg::ARB_DL,
				psx_bus_pkg::ARB_SYS: begin
					if (ram_ack) begin
						state     <= psx_bus_pkg::ARB_IDLE;
						ram_valid <= 1'b0;
					end
				end
				default: begin
					state     <= psx_bus_pkg::ARB_IDLE;
					ram_valid <= 1'b0;
				end
			endcase
		end
	end

	// Request captured while idle and frozen during the grant
	always_ff @(posedge clk_1x) begin
		if (state == psx_bus_pkg::ARB_IDLE)
			ram_req <= dl_valid ? dl_req : sys_req;
	end

	assign dl_ack    = ram_ack && (state == psx_bus_pkg::ARB_DL);
	assign sys_ack   = ram_ack && (state == psx_bus_pkg::ARB_SYS);
	assign sys_rdata = ram_rdata;

	// Memory only answers an open request
	a_ack_needs_valid: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		ram_ack |-> ram_valid
	);

	// System requester holds its request until acknowledged
	a_sys_held: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		sys_valid && !sys_ack |=> sys_valid && $stable(sys_req)
	);

endmodule

//--- src/media_mount.sv
`timescale 1ns/100ps

module media_mount (
	input  logic                                clk_1x,
	input  logic                                arst_n,
	input  psx_bus_pkg::mount_t                 mount,
	input  logic                                cd_loaded,
	input  psx_bus_pkg::ram_addr_t              host_addr,
	input  logic                                bk_load,
	input  logic                                bk_save,
	input  logic                                bk_autosave,
	input  logic                                osd_status,
	output logic                                has_cd,
	output psx_bus_pkg::cd_size_t               cd_size,
	output logic [psx_cfg_pkg::CARD_COUNT-1:0] card_available,
	output logic [psx_cfg_pkg::CARD_COUNT-1:0] card_load,
	output logic                                card_save
);

	logic size_valid;
	logic save_a;
	logic old_load;
	logic old_save;
	logic old_save_a;

	assign size_valid = (mount.size != '0);

	// Autosave only counts while the menu is open
	assign save_a = osd_status & bk_autosave;

	// ============================================================
	// Mount flags and card pulses
	// ============================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			has_cd         <= 1'b0;
			card_available <= '0;
			card_load      <= '0;
			card_save      <= 1'b0;
			old_load       <= 1'b0;
			old_save       <= 1'b0;
			old_save_a     <= 1'b0;
		end else begin
			card_load <= '0;
			card_save <= 1'b0;

			if (cd_loaded)
				has_cd <= 1'b1;
			if (mount.cd)
				has_cd <= size_valid;

			for (int i = 0; i < psx_cfg_pkg::CARD_COUNT; i++) begin
				if (mount.card[i]) begin
					card_available[i] <= size_valid;
					card_load[i]      <= size_valid;
				end
			end

			old_load   <= bk_load;
			old_save   <= bk_save;
			old_save_a <= save_a;

			// Reload request hits every slot
			if (bk_load && !old_load)
				card_load <= '1;
			if ((bk_save && !old_save) || (save_a && !old_save_a))
				card_save <= 1'b1;
		end
	end

	// Size follows whichever source came last
	always_ff @(posedge clk_1x) begin
		if (cd_loaded)
			cd_size <= psx_bus_pkg::cd_size_t'(host_addr);
		if (mount.cd && size_valid)
			cd_size <= psx_bus_pkg::cd_size_t'(mount.size);
	end

endmodule

//--- src/psx_loader_top.sv
`timescale 1ns/100ps

module psx_loader_top (
	input  logic                                clk_1x,
	input  logic                                arst_n,
	input  psx_bus_pkg::host_dl_t               host,
	output logic                                host_wait,
	input  psx_bus_pkg::ram_req_t               sys_req,
	input  logic                                sys_valid,
	output logic                                sys_ack,
	output psx_bus_pkg::ram_word_t              sys_rdata,
	output psx_bus_pkg::ram_req_t               ram_req,
	output logic                                ram_valid,
	input  logic                                ram_ack,
	input  psx_bus_pkg::ram_word_t              ram_rdata,
	input  psx_bus_pkg::mount_t                 mount,
	input  logic                                bk_load,
	input  logic                                bk_save,
	input  logic                                bk_autosave,
	input  logic                                osd_status,
	output logic                                system_reset,
	output logic                                exe_loaded,
	output logic                                has_cd,
	output psx_bus_pkg::cd_size_t               cd_size,
	output logic [psx_cfg_pkg::CARD_COUNT-1:0] card_available,
	output logic [psx_cfg_pkg::CARD_COUNT-1:0] card_load,
	output logic                                card_save
);

	psx_bus_pkg::dl_kind_e dl_kind;
	psx_bus_pkg::ram_req_t dl_req;
	logic                  dl_valid;
	logic                  dl_ack;
	logic                  cd_loaded;

	// ============================================================
	// Download path
	// ============================================================

	download_decoder u_decoder (
		.clk_1x       (clk_1x),
		.arst_n       (arst_n),
		.host         (host),
		.dl_kind      (dl_kind),
		.system_reset (system_reset),
		.exe_loaded   (exe_loaded),
		.cd_loaded    (cd_loaded)
	);

	download_packer u_packer (
		.clk_1x    (clk_1x),
		.arst_n    (arst_n),
		.host      (host),
		.dl_kind   (dl_kind),
		.dl_req    (dl_req),
		.dl_valid  (dl_valid),
		.dl_ack    (dl_ack),
		.host_wait (host_wait)
	);

	// ============================================================
	// RAM bus
	// ============================================================

	mem_arbiter u_arbiter (
		.clk_1x    (clk_1x),
		.arst_n    (arst_n),
		.dl_kind   (dl_kind),
		.dl_req    (dl_req),
		.dl_valid  (dl_valid),
		.dl_ack    (dl_ack),
		.sys_req   (sys_req),
		.sys_valid (sys_valid),
		.sys_ack   (sys_ack),
		.sys_rdata (sys_rdata),
		.ram_req   (ram_req),
		.ram_valid (ram_valid),
		.ram_ack   (ram_ack),
		.ram_rdata (ram_rdata)
	);

	// ============================================================
	// Media
	// ============================================================

	media_mount u_media (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.mount          (mount),
		.cd_loaded      (cd_loaded),
		.host_addr      (host.addr),
		.bk_load        (bk_load),
		.bk_save        (bk_save),
		.bk_autosave    (bk_autosave),
		.osd_status     (osd_status),
		.has_cd         (has_cd),
		.cd_size        (cd_size),
		.card_available (card_available),
		.card_load      (card_load),
		.card_save      (card_save)
	);

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps

module tb_top;

	localparam logic [31:0] SEED = 32'he87ba885;
	localparam int BIOS_WORDS   = 16;
	localparam int EXE_WORDS    = 16;
	localparam int SYS_OPS      = 24;
	localparam int MIX_WORDS    = 16;
	localparam int CD_WORDS     = 12;
	localparam int MOUNT_EVENTS = 12;
	localparam int TOTAL_WORDS  = BIOS_WORDS + EXE_WORDS + SYS_OPS + MIX_WORDS +
		CD_WORDS + MOUNT_EVENTS;

	logic                                clk_1x;
	logic                                arst_n;
	psx_bus_pkg::host_dl_t               host;
	logic                                host_wait;
	psx_bus_pkg::ram_req_t               sys_req;
	logic                                sys_valid;
	logic                                sys_ack;
	psx_bus_pkg::ram_word_t              sys_rdata;
	psx_bus_pkg::ram_req_t               ram_req;
	logic                                ram_valid;
	logic                                ram_ack;
	psx_bus_pkg::ram_word_t              ram_rdata;
	psx_bus_pkg::mount_t                 mount;
	logic                                bk_load;
	logic                                bk_save;
	logic                                bk_autosave;
	logic                                osd_status;
	logic                                system_reset;
	logic                                exe_loaded;
	logic                                has_cd;
	psx_bus_pkg::cd_size_t               cd_size;
	logic [psx_cfg_pkg::CARD_COUNT-1:0] card_available;
	logic [psx_cfg_pkg::CARD_COUNT-1:0] card_load;
	logic                                card_save;

	logic [31:0] stim_seed;
	psx_bus_pkg::ram_word_t model_mem [psx_bus_pkg::ram_addr_t];
	psx_bus_pkg::ram_req_t  exp_writes [$];
	int errors = 0;
	int ram_errors = 0;
	int writes_done = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;
	int exe_cnt = 0;
	int save_cnt = 0;
	int load0_cnt = 0;
	int load1_cnt = 0;

	psx_loader_top uut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #50 clk_1x = ~clk_1x;
	end

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] stim_rand();
		stim_seed = lcg(stim_seed);
		return stim_seed;
	endfunction

	// Untouched RAM reads back a pattern of its address
	function automatic psx_bus_pkg::ram_word_t fill_word(input psx_bus_pkg::ram_addr_t a);
		return (32'(a) * 32'h9e3779b1) ^ 32'h5a3c96e1;
	endfunction

	function automatic psx_bus_pkg::ram_word_t merge_bytes(input psx_bus_pkg::ram_word_t old,
		input psx_bus_pkg::ram_word_t d, input psx_bus_pkg::ram_be_t be);
		psx_bus_pkg::ram_word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				w[8*b +: 8] = d[8*b +: 8];
		end
		return w;
	endfunction

	function automatic psx_bus_pkg::ram_word_t model_read(input psx_bus_pkg::ram_addr_t a);
		return model_mem.exists(a) ? model_mem[a] : fill_word(a);
	endfunction

	task automatic step();
		@(posedge clk_1x);
		#10;
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors + ram_errors - test_err_base;
		tests_run++;
		if (n == 0) begin
			$display("test %-16s ok", name);
		end else begin
			tests_failed++;
			$display("test %-16s FAILED with %0d errors", name, n);
		end
		test_err_base = errors + ram_errors;
	endtask

	// ============================================================
	// RAM responder
	// ============================================================

	initial begin : ram_responder
		logic [31:0] delay_seed;
		int delay;
		psx_bus_pkg::ram_req_t exp;
		psx_bus_pkg::ram_word_t mem [psx_bus_pkg::ram_addr_t];
		psx_bus_pkg::ram_addr_t a;
		delay_seed = SEED;
		ram_ack = 1'b0;
		ram_rdata = '0;
		forever begin
			step();
			ram_ack = 1'b0;
			if (ram_valid) begin
				delay_seed = lcg(delay_seed);
				delay = int'((delay_seed >> 16) % 32'd6);
				repeat (delay)
					step();
				a = ram_req.addr;
				if (ram_req.rnw) begin
					ram_rdata = mem.exists(a) ? mem[a] : fill_word(a);
				end else begin
					if (writes_done >= exp_writes.size()) begin
						$display("Unexpected RAM write to address %h", a);
						ram_errors++;
					end else begin
						exp = exp_writes[writes_done];
						if (ram_req.addr != exp.addr || ram_req.be != exp.be) begin
							$display("Error: ram_req.addr %h be %h, expected %h be %h",
								ram_req.addr, ram_req.be, exp.addr, exp.be);
							ram_errors++;
						end
						if (ram_req.wdata != exp.wdata) begin
							$display("Error: ram_req.wdata %h, expected %h",
								ram_req.wdata, exp.wdata);
							ram_errors++;
						end
					end
					mem[a] = merge_bytes(mem.exists(a) ? mem[a] : fill_word(a),
						ram_req.wdata, ram_req.be);
					writes_done++;
				end
				ram_ack = 1'b1;
			end
		end
	end

	// Pulse counters, sampled on the clock edge
	always @(posedge clk_1x) begin
		if (exe_loaded)
			exe_cnt++;
		if (card_save)
			save_cnt++;
		if (card_load[0])
			load0_cnt++;
		if (card_load[1])
			load1_cnt++;
	end

	// ============================================================
	// Host and system side stimulus
	// ============================================================

	task automatic download(input psx_bus_pkg::dl_index_t idx, input int words,
		input psx_bus_pkg::ram_addr_t base, input logic to_ram);
		psx_bus_pkg::host_word_t lo;
		psx_bus_pkg::ram_req_t w;
		host.active = 1'b1;
		host.index = idx;
		step();
		for (int i = 0; i < words; i++) begin
			while (host_wait)
				step();
			if (!system_reset) begin
				$display("Error: system_reset %h during download word %0d, expected 1",
					system_reset, i);
				errors++;
			end
			host.addr = psx_bus_pkg::ram_addr_t'(2 * i);
			host.data = psx_bus_pkg::host_word_t'(stim_rand() >> 8);
			host.wr = 1'b1;
			if (i % 2 == 0) begin
				lo = host.data;
			end else if (to_ram) begin
				// Pair lands on the even half-word address
				w.addr = host.addr - 27'd2 + base;
				w.wdata = {host.data, lo};
				w.be = 4'hf;
				w.rnw = 1'b0;
				exp_writes.push_back(w);
				model_mem[w.addr] = w.wdata;
			end
			step();
			host.wr = 1'b0;
			if (!to_ram && host_wait) begin
				$display("Error: host_wait %h during a download that skips RAM, expected 0",
					host_wait);
				errors++;
			end
		end
		while (host_wait)
			step();
		if (writes_done != exp_writes.size()) begin
			$display("Download ended with %0d RAM writes outstanding",
				exp_writes.size() - writes_done);
			errors++;
		end
		host.active = 1'b0;
	endtask

	task automatic sys_access(input logic rnw, input psx_bus_pkg::ram_addr_t a,
		input psx_bus_pkg::ram_word_t d, input psx_bus_pkg::ram_be_t be,
		output int acked_writes);
		psx_bus_pkg::ram_word_t expect_rd;
		expect_rd = model_read(a);
		sys_req.addr = a;
		sys_req.wdata = d;
		sys_req.be = be;
		sys_req.rnw = rnw;
		sys_valid = 1'b1;
		if (!rnw) begin
			exp_writes.push_back(sys_req);
			model_mem[a] = merge_bytes(expect_rd, d, be);
		end
		do
			@(posedge clk_1x);
		while (!sys_ack);
		acked_writes = writes_done;
		if (rnw && sys_rdata != expect_rd) begin
			$display("Error: sys_rdata %h, expected %h at address %h", sys_rdata, expect_rd, a);
			errors++;
		end
		#10;
		sys_valid = 1'b0;
	endtask

	task automatic mount_pulse(input logic cd, input logic [1:0] card, input logic [31:0] size);
		mount.cd = cd;
		mount.card = card;
		mount.size = size;
		step();
		mount.cd = 1'b0;
		mount.card = 2'b00;
		repeat (2)
			step();
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin : main
		int seen;
		int base_w;
		int l0;
		int l1;
		int s0;
		logic [31:0] r;
		psx_bus_pkg::ram_be_t be;
		arst_n = 1'b0;
		host = '0;
		sys_req = '0;
		sys_valid = 1'b0;
		mount = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_autosave = 1'b0;
		osd_status = 1'b0;
		stim_seed = SEED;
		repeat (4)
			@(posedge clk_1x);
		#10;
		arst_n = 1'b1;
		step();

		if (host_wait || ram_valid || sys_ack || card_load != 2'b00 || card_save ||
			exe_loaded || has_cd || card_available != 2'b00 || system_reset) begin
			$display("Outputs were not idle after reset");
			errors++;
		end
		end_test("reset");

		download(8'd0, BIOS_WORDS, psx_bus_pkg::ram_addr_t'(psx_cfg_pkg::BIOS_START), 1'b1);
		end_test("bios download");

		l0 = exe_cnt;
		download(8'd1, EXE_WORDS, psx_bus_pkg::ram_addr_t'(psx_cfg_pkg::EXE_START), 1'b1);
		repeat (6)
			step();
		if (exe_cnt - l0 != 1) begin
			$display("Error: exe_loaded pulses %h after the EXE download, expected 1",
				exe_cnt - l0);
			errors++;
		end
		end_test("exe download");

		// Small address window so reads hit earlier writes
		for (int i = 0; i < SYS_OPS; i++) begin
			r = stim_rand();
			be = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
			sys_access(r[31], psx_bus_pkg::ram_addr_t'(r & 32'h0000_00fc), stim_rand(),
				be, seen);
		end
		end_test("system traffic");

		base_w = writes_done;
		fork
			download(8'd0, MIX_WORDS, psx_bus_pkg::ram_addr_t'(psx_cfg_pkg::BIOS_START), 1'b1);
			begin
				repeat (4)
					step();
				sys_access(1'b1, 27'h0000_0f0, '0, 4'hf, seen);
			end
		join
		if (seen != base_w + MIX_WORDS / 2) begin
			$display("System read was acknowledged before the download finished");
			errors++;
		end
		end_test("system in dl");

		base_w = writes_done;
		download(8'h42, CD_WORDS, '0, 1'b0);
		repeat (6)
			step();
		if (writes_done != base_w) begin
			$display("CD download wrote to RAM");
			errors++;
		end
		if (!has_cd) begin
			$display("Error: has_cd %h after the CD download, expected 1", has_cd);
			errors++;
		end
		if (cd_size != psx_bus_pkg::cd_size_t'(2 * (CD_WORDS - 1))) begin
			$display("Error: cd_size %h, expected %h", cd_size, 2 * (CD_WORDS - 1));
			errors++;
		end
		end_test("cd download");

		l0 = load0_cnt;
		l1 = load1_cnt;
		mount_pulse(1'b0, 2'b01, 32'h0002_0000);
		mount_pulse(1'b0, 2'b10, 32'h0002_0000);
		if (card_available != 2'b11 || load0_cnt - l0 != 1 || load1_cnt - l1 != 1) begin
			$display("Error: card_available %h, loads %h %h, expected 3 1 1",
				card_available, load0_cnt - l0, load1_cnt - l1);
			errors++;
		end
		mount_pulse(1'b0, 2'b01, 32'h0);
		if (card_available != 2'b10 || load0_cnt - l0 != 1) begin
			$display("Error: card_available %h after empty mount, expected 2", card_available);
			errors++;
		end

		// Reload, save and autosave with the menu open
		l0 = load0_cnt;
		l1 = load1_cnt;
		s0 = save_cnt;
		bk_load = 1'b1;
		bk_save = 1'b1;
		repeat (3)
			step();
		bk_load = 1'b0;
		bk_save = 1'b0;
		osd_status = 1'b1;
		bk_autosave = 1'b1;
		repeat (3)
			step();
		bk_autosave = 1'b0;
		osd_status = 1'b0;
		step();
		if (load0_cnt - l0 != 1 || load1_cnt - l1 != 1 || save_cnt - s0 != 2) begin
			$display("Error: card pulses load %h %h save %h, expected 1 1 2",
				load0_cnt - l0, load1_cnt - l1, save_cnt - s0);
			errors++;
		end

		// Empty CD mount ejects the disc
		mount_pulse(1'b1, 2'b00, 32'h0);
		if (has_cd) begin
			$display("Error: has_cd %h after empty CD mount, expected 0", has_cd);
			errors++;
		end

		mount_pulse(1'b1, 2'b00, 32'h1234_5678);
		if (!has_cd || cd_size != psx_bus_pkg::cd_size_t'(32'h1234_5678)) begin
			$display("Error: has_cd %h cd_size %h, expected 1 %h", has_cd, cd_size,
				psx_bus_pkg::cd_size_t'(32'h1234_5678));
			errors++;
		end
		end_test("media mounts");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			errors + ram_errors);
		if (tests_failed == 0 && errors + ram_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Generous bound of 20 cycles per word or event
	initial begin : watchdog
		repeat (TOTAL_WORDS * 20)
			@(posedge clk_1x);
		$display("Watchdog expired after %0d cycles, the run did not finish", TOTAL_WORDS * 20);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- tb.f
src/psx_cfg_pkg.sv
src/psx_bus_pkg.sv
src/download_decoder.sv
src/download_packer.sv
src/mem_arbiter.sv
src/media_mount.sv
src/psx_loader_top.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
	exit 0
fi
exit 1
